/* hdl/ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data path width
`define XLEN 32

// Register index width, x0..x31
`define REG_AW 5

// One enable per byte lane of a data word
`define BE_W 4

`endif

/* hdl/rv32i_types_pkg.sv */
`default_nettype none

`include "ex_defines.svh"

package rv32i_types_pkg;

  typedef logic [`XLEN-1:0] rv32i_word;

  // Major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode_e;

  // Access size, shared by loads and stores
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,  // Unsigned forms exist for loads only
    lhu = 3'b101
  } ld_st_funct3_e;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_e;

endpackage

`default_nettype wire

/* hdl/ex_ctrl_pkg.sv */
`default_nettype none

package ex_ctrl_pkg;

  // Low three bits follow funct3, bit 3 is funct7[5]
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_e;

  // Operand source, EX/MEM has priority over MEM/WB
  typedef enum logic [1:0] {
    fwd_none   = 2'b00,
    fwd_mem_wb = 2'b01,
    fwd_ex_mem = 2'b10
  } fwd_sel_e;

  typedef enum logic {
    pc_plus4  = 1'b0,
    pc_target = 1'b1
  } pcmux_sel_e;

endpackage

`default_nettype wire

/* hdl/ex_forward.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_forward
  import rv32i_types_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  rv32i_word           instr_i,
  input  rv32i_opcode_e       opcode_i,
  input  rv32i_word           op_a_i,
  input  rv32i_word           op_b_i,
  input  rv32i_word           rs1_data_i,
  input  rv32i_word           rs2_data_i,
  input  rv32i_word           cmp_b_i,
  input  rv32i_opcode_e       exm_opcode_i,
  input  logic [`REG_AW-1:0]  exm_rd_i,
  input  rv32i_word           exm_alu_i,
  input  logic                mem_wb_we_i,
  input  logic [`REG_AW-1:0]  mem_wb_rd_i,
  input  rv32i_word           mem_wb_data_i,
  output rv32i_word           alu_a_o,
  output rv32i_word           alu_b_o,
  output rv32i_word           cmp_a_o,
  output rv32i_word           cmp_b_o,
  output rv32i_word           store_data_o
);

  logic [`REG_AW-1:0] rs1, rs2;
  logic exm_wr;
  logic exm_hit1, exm_hit2, wb_hit1, wb_hit2;
  logic a_en, b_en, ca_en, cb_en;
  fwd_sel_e sel_a, sel_b, sel_ca, sel_cb, sel_st;

  function automatic fwd_sel_e pick(input logic en, input logic exm_hit, input logic wb_hit);
    if (!en) return fwd_none;
    else if (exm_hit) return fwd_ex_mem;
    else if (wb_hit) return fwd_mem_wb;
    else return fwd_none;
  endfunction

  function automatic rv32i_word fwd_mux(input fwd_sel_e sel, input rv32i_word base,
                                        input rv32i_word exm, input rv32i_word wb);
    case (sel)
      fwd_ex_mem: return exm;
      fwd_mem_wb: return wb;
      default:    return base;
    endcase
  endfunction

  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];

  // Branches and stores leave rd unwritten, zero opcode after reset too
  assign exm_wr = exm_opcode_i inside {op_lui, op_auipc, op_jal, op_jalr,
                                       op_load, op_imm, op_reg};

  assign exm_hit1 = exm_wr && (exm_rd_i != '0) && (exm_rd_i == rs1);
  assign exm_hit2 = exm_wr && (exm_rd_i != '0) && (exm_rd_i == rs2);
  assign wb_hit1  = mem_wb_we_i && (mem_wb_rd_i != '0) && (mem_wb_rd_i == rs1);
  assign wb_hit2  = mem_wb_we_i && (mem_wb_rd_i != '0) && (mem_wb_rd_i == rs2);

  // Which operands carry a register value for this opcode
  assign a_en  = opcode_i inside {op_reg, op_imm, op_load, op_store, op_jalr};
  assign b_en  = (opcode_i == op_reg);
  assign ca_en = opcode_i inside {op_br, op_reg, op_imm};  // rs1 side of compares
  assign cb_en = (opcode_i == op_br);

  assign sel_a  = pick(a_en, exm_hit1, wb_hit1);
  assign sel_b  = pick(b_en, exm_hit2, wb_hit2);
  assign sel_ca = pick(ca_en, exm_hit1, wb_hit1);
  assign sel_cb = pick(cb_en, exm_hit2, wb_hit2);
  assign sel_st = pick(1'b1, exm_hit2, wb_hit2);

  assign alu_a_o      = fwd_mux(sel_a, op_a_i, exm_alu_i, mem_wb_data_i);
  assign alu_b_o      = fwd_mux(sel_b, op_b_i, exm_alu_i, mem_wb_data_i);
  assign cmp_a_o      = fwd_mux(sel_ca, rs1_data_i, exm_alu_i, mem_wb_data_i);
  assign cmp_b_o      = fwd_mux(sel_cb, cmp_b_i, exm_alu_i, mem_wb_data_i);
  assign store_data_o = fwd_mux(sel_st, rs2_data_i, exm_alu_i, mem_wb_data_i);

endmodule

`default_nettype wire

/* hdl/ex_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_alu
  import rv32i_types_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  alu_op_e   aluop_i,
  input  rv32i_word a_i,
  input  rv32i_word b_i,
  output rv32i_word res_o,
  output rv32i_word jump_tgt_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];  // Only the low five bits count

  always_comb begin
    case (aluop_i)
      alu_add:  res_o = a_i + b_i;
      alu_sub:  res_o = a_i - b_i;
      alu_sll:  res_o = a_i << shamt;
      alu_slt:  res_o = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      alu_sltu: res_o = {{(`XLEN-1){1'b0}}, a_i < b_i};
      alu_xor:  res_o = a_i ^ b_i;
      alu_srl:  res_o = a_i >> shamt;
      alu_sra:  res_o = rv32i_word'($signed(a_i) >>> shamt);
      alu_or:   res_o = a_i | b_i;
      alu_and:  res_o = a_i & b_i;
      default:  res_o = '0;
    endcase
  end

  // jalr needs the LSB dropped, jal targets are even anyway
  assign jump_tgt_o = {res_o[`XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

/* hdl/ex_cmp.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_cmp
  import rv32i_types_pkg::*;
(
  input  branch_funct3_e cmpop_i,
  input  rv32i_word      a_i,
  input  rv32i_word      b_i,
  output logic           br_en_o
);

  logic eq, lt_s, lt_u;

  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    case (cmpop_i)
      beq:     br_en_o = eq;
      bne:     br_en_o = !eq;
      blt:     br_en_o = lt_s;
      bge:     br_en_o = !lt_s;
      bltu:    br_en_o = lt_u;
      bgeu:    br_en_o = !lt_u;
      default: br_en_o = 1'b0;  // 3'b010 and 3'b011 are not branches
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_resolve.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_resolve
  import rv32i_types_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                ma_stall_i,
  input  rv32i_word           pc_i,
  input  rv32i_word           instr_i,
  input  rv32i_opcode_e       opcode_i,
  input  logic                pred_i,
  input  rv32i_word           alu_res_i,
  input  rv32i_word           jump_tgt_i,
  input  logic                br_en_i,
  input  rv32i_word           store_data_i,
  output pcmux_sel_e          pcmux_sel_o,
  output rv32i_word           target_o,
  output logic                br_miss_o,
  output logic                pred_update_o,
  output logic                pred_taken_o,
  output rv32i_opcode_e       ex_opcode_o,
  output logic [`REG_AW-1:0]  ex_rd_o,
  output rv32i_word           ex_pc_o,
  output rv32i_word           ex_alu_o,
  output rv32i_word           ex_store_o,
  output logic                ex_br_en_o,
  output logic [`BE_W-1:0]    ex_be_o,
  output logic [1:0]          ex_off_o
);

  rv32i_word pc_next;
  logic [`BE_W-1:0] size_mask, be_next;
  logic mem_op;

  assign pc_next = pc_i + `XLEN'd4;
  assign mem_op  = (opcode_i == op_load) || (opcode_i == op_store);

  // Redirect decision against the one-bit prediction
  always_comb begin
    pcmux_sel_o = pc_plus4;
    target_o    = pc_next;
    br_miss_o   = 1'b0;
    if (opcode_i == op_jal || opcode_i == op_jalr) begin
      pcmux_sel_o = pc_target;  // Jumps are never predicted
      target_o    = jump_tgt_i;
      br_miss_o   = 1'b1;
    end else if (opcode_i == op_br && br_en_i != pred_i) begin
      pcmux_sel_o = pc_target;
      target_o    = pred_i ? pc_next : alu_res_i;  // Undo a wrong taken guess
      br_miss_o   = 1'b1;
    end
  end

  assign pred_update_o = (opcode_i == op_br);
  assign pred_taken_o  = br_en_i;

  always_comb begin
    case (ld_st_funct3_e'(instr_i[14:12]))
      lw:       size_mask = 4'hF;
      lh, lhu:  size_mask = 4'h3;
      lb, lbu:  size_mask = 4'h1;
      default:  size_mask = '0;
    endcase
  end

  assign be_next = mem_op ? (size_mask << alu_res_i[1:0]) : '0;

  // EX/MEM register, frozen while memory stalls
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_opcode_o <= rv32i_opcode_e'(7'b0);
      ex_rd_o     <= '0;
      ex_pc_o     <= '0;
      ex_alu_o    <= '0;
      ex_store_o  <= '0;
      ex_br_en_o  <= 1'b0;
      ex_be_o     <= '0;
      ex_off_o    <= '0;
    end else if (!ma_stall_i) begin
      ex_opcode_o <= opcode_i;
      ex_rd_o     <= instr_i[11:7];
      ex_pc_o     <= pc_i;
      ex_alu_o    <= alu_res_i;
      ex_store_o  <= store_data_i;
      ex_br_en_o  <= br_en_i;
      ex_be_o     <= be_next;
      ex_off_o    <= alu_res_i[1:0];
    end
  end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_stage
  import rv32i_types_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  // Decode
  input  rv32i_word           pc_i,
  input  rv32i_word           instr_i,
  input  rv32i_opcode_e       opcode_i,
  input  alu_op_e             aluop_i,
  input  branch_funct3_e      cmpop_i,
  input  rv32i_word           op_a_i,
  input  rv32i_word           op_b_i,
  input  rv32i_word           rs1_data_i,
  input  rv32i_word           rs2_data_i,
  input  rv32i_word           cmp_b_i,
  // Writeback
  input  logic                mem_wb_we_i,
  input  logic [`REG_AW-1:0]  mem_wb_rd_i,
  input  rv32i_word           mem_wb_data_i,
  input  logic                pred_i,
  input  logic                ma_stall_i,
  output pcmux_sel_e          pcmux_sel_o,
  output rv32i_word           target_o,
  output logic                br_miss_o,
  output logic                pred_update_o,
  output logic                pred_taken_o,
  output rv32i_opcode_e       ex_opcode_o,
  output logic [`REG_AW-1:0]  ex_rd_o,
  output rv32i_word           ex_pc_o,
  output rv32i_word           ex_alu_o,
  output rv32i_word           ex_store_o,
  output logic                ex_br_en_o,
  output logic [`BE_W-1:0]    ex_be_o,
  output logic [1:0]          ex_off_o
);

  rv32i_word alu_a, alu_b, cmp_a, cmp_b, store_data;
  rv32i_word alu_res, jump_tgt;
  logic br_en;

  ex_forward u_fwd (
    .instr_i       (instr_i),
    .opcode_i      (opcode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .cmp_b_i       (cmp_b_i),
    .exm_opcode_i  (ex_opcode_o),  // Fed back from the EX/MEM register
    .exm_rd_i      (ex_rd_o),
    .exm_alu_i     (ex_alu_o),
    .mem_wb_we_i   (mem_wb_we_i),
    .mem_wb_rd_i   (mem_wb_rd_i),
    .mem_wb_data_i (mem_wb_data_i),
    .alu_a_o       (alu_a),
    .alu_b_o       (alu_b),
    .cmp_a_o       (cmp_a),
    .cmp_b_o       (cmp_b),
    .store_data_o  (store_data)
  );

  ex_alu u_alu (
    .aluop_i    (aluop_i),
    .a_i        (alu_a),
    .b_i        (alu_b),
    .res_o      (alu_res),
    .jump_tgt_o (jump_tgt)
  );

  ex_cmp u_cmp (
    .cmpop_i (cmpop_i),
    .a_i     (cmp_a),
    .b_i     (cmp_b),
    .br_en_o (br_en)
  );

  ex_resolve u_res (
    .clk           (clk),
    .rst           (rst),
    .ma_stall_i    (ma_stall_i),
    .pc_i          (pc_i),
    .instr_i       (instr_i),
    .opcode_i      (opcode_i),
    .pred_i        (pred_i),
    .alu_res_i     (alu_res),
    .jump_tgt_i    (jump_tgt),
    .br_en_i       (br_en),
    .store_data_i  (store_data),
    .pcmux_sel_o   (pcmux_sel_o),
    .target_o      (target_o),
    .br_miss_o     (br_miss_o),
    .pred_update_o (pred_update_o),
    .pred_taken_o  (pred_taken_o),
    .ex_opcode_o   (ex_opcode_o),
    .ex_rd_o       (ex_rd_o),
    .ex_pc_o       (ex_pc_o),
    .ex_alu_o      (ex_alu_o),
    .ex_store_o    (ex_store_o),
    .ex_br_en_o    (ex_br_en_o),
    .ex_be_o       (ex_be_o),
    .ex_off_o      (ex_off_o)
  );

endmodule

`default_nettype wire

/* sim/ex_stage_assert.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_stage_assert
  import rv32i_types_pkg::*;
  import ex_ctrl_pkg::*;
(
  input logic               clk,
  input logic               rst,
  input rv32i_opcode_e      opcode_i,
  input logic               ma_stall_i,
  input pcmux_sel_e         pcmux_sel_o,
  input logic               br_miss_o,
  input logic               pred_update_o,
  input rv32i_opcode_e      ex_opcode_o,
  input logic [`REG_AW-1:0] ex_rd_o,
  input rv32i_word          ex_pc_o,
  input rv32i_word          ex_alu_o,
  input rv32i_word          ex_store_o,
  input logic               ex_br_en_o,
  input logic [`BE_W-1:0]   ex_be_o,
  input logic [1:0]         ex_off_o
);

  int fail_count = 0;

  a_miss_sel: assert property (@(posedge clk) disable iff (rst)
    br_miss_o |-> pcmux_sel_o == pc_target)
    else begin
      fail_count++;
      $error("br_miss_o without the target select");
    end

  a_pred_upd: assert property (@(posedge clk) disable iff (rst)
    pred_update_o == (opcode_i == op_br))
    else begin
      fail_count++;
      $error("pred_update_o does not follow the branch opcode");
    end

  // Byte lanes only for memory accesses
  a_be_mem: assert property (@(posedge clk) disable iff (rst)
    (ex_be_o != '0) |-> ex_opcode_o inside {op_load, op_store})
    else begin
      fail_count++;
      $error("ex_be_o set for a non-memory opcode");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    ma_stall_i |=> $stable({ex_opcode_o, ex_rd_o, ex_pc_o, ex_alu_o, ex_store_o,
                            ex_br_en_o, ex_be_o, ex_off_o}))
    else begin
      fail_count++;
      $error("EX/MEM register changed during a stall");
    end

endmodule

bind ex_stage ex_stage_assert u_assert (
  .clk           (clk),
  .rst           (rst),
  .opcode_i      (opcode_i),
  .ma_stall_i    (ma_stall_i),
  .pcmux_sel_o   (pcmux_sel_o),
  .br_miss_o     (br_miss_o),
  .pred_update_o (pred_update_o),
  .ex_opcode_o   (ex_opcode_o),
  .ex_rd_o       (ex_rd_o),
  .ex_pc_o       (ex_pc_o),
  .ex_alu_o      (ex_alu_o),
  .ex_store_o    (ex_store_o),
  .ex_br_en_o    (ex_br_en_o),
  .ex_be_o       (ex_be_o),
  .ex_off_o      (ex_off_o)
);

`default_nettype wire

/* sim/tb_ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module tb_ex_stage
  import rv32i_types_pkg::*;
  import ex_ctrl_pkg::*;
();

  localparam int TIMEOUT_CYC = 20;

  typedef struct {
    int                 tid;
    rv32i_opcode_e      opc;
    alu_op_e            aluop;
    branch_funct3_e     cmpop;
    rv32i_word          instr, pc, op_a, op_b, rs1d, rs2d, cmpb;
    logic               wb_we;
    logic [`REG_AW-1:0] wb_rd;
    rv32i_word          wb_data;
    logic               pred, stall;
    logic               exp_miss, exp_upd, exp_taken;
    rv32i_word          exp_tgt;
  } row_t;

  logic clk;
  logic rst;
  rv32i_word pc, instr, op_a, op_b, rs1_data, rs2_data, cmp_b, mem_wb_data;
  rv32i_opcode_e opcode;
  alu_op_e aluop;
  branch_funct3_e cmpop;
  logic mem_wb_we, pred, ma_stall;
  logic [`REG_AW-1:0] mem_wb_rd;
  pcmux_sel_e pcmux_sel;
  rv32i_word target, ex_pc, ex_alu, ex_store;
  logic br_miss, pred_update, pred_taken, ex_br_en;
  rv32i_opcode_e ex_opcode;
  logic [`REG_AW-1:0] ex_rd;
  logic [`BE_W-1:0] ex_be;
  logic [1:0] ex_off;

  // Shadow copy of the EX/MEM register
  rv32i_opcode_e sh_opcode;
  logic [`REG_AW-1:0] sh_rd;
  rv32i_word sh_pc, sh_alu, sh_store;
  logic sh_br_en;
  logic [`BE_W-1:0] sh_be;
  logic [1:0] sh_off;

  row_t rows[$];
  integer seed;
  int n_pass, n_fail, cur_tid, cur_row;
  int test_err [1:5];
  string test_names [1:5] = '{"alu and byte enables", "forwarding", "branches", "jumps",
                              "stall and reset"};

  ex_stage u_dut (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (pc),
    .instr_i       (instr),
    .opcode_i      (opcode),
    .aluop_i       (aluop),
    .cmpop_i       (cmpop),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .cmp_b_i       (cmp_b),
    .mem_wb_we_i   (mem_wb_we),
    .mem_wb_rd_i   (mem_wb_rd),
    .mem_wb_data_i (mem_wb_data),
    .pred_i        (pred),
    .ma_stall_i    (ma_stall),
    .pcmux_sel_o   (pcmux_sel),
    .target_o      (target),
    .br_miss_o     (br_miss),
    .pred_update_o (pred_update),
    .pred_taken_o  (pred_taken),
    .ex_opcode_o   (ex_opcode),
    .ex_rd_o       (ex_rd),
    .ex_pc_o       (ex_pc),
    .ex_alu_o      (ex_alu),
    .ex_store_o    (ex_store),
    .ex_br_en_o    (ex_br_en),
    .ex_be_o       (ex_be),
    .ex_off_o      (ex_off)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #5;
    rst = 1'b0;
  end

  // Hard stop in case the main sequence gets stuck
  initial begin
    #200000;
    $display("Simulation did not finish within its time limit");
    $display("Verification failed");
    $finish;
  end

  function automatic rv32i_word enc(rv32i_opcode_e opc, logic [4:0] rd, logic [2:0] f3,
                                    logic [4:0] rs1, logic [4:0] rs2);
    return {7'b0, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic row_t new_row(int tid, rv32i_opcode_e opc, alu_op_e op, rv32i_word ins,
                                   rv32i_word a, rv32i_word b);
    rv32i_word pc_row;
    pc_row = 32'h100 + 32'(rows.size() * 4);
    return '{tid, opc, op, beq, ins, pc_row, a, b, a, b, b, 1'b0, 5'd0, 32'd0,
             1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0};
  endfunction

  function automatic rv32i_word ref_alu(alu_op_e op, rv32i_word a, rv32i_word b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[4:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[4:0];
      alu_sra:  return $signed(a) >>> b[4:0];
      alu_or:   return a | b;
      alu_and:  return a & b;
      default:  return 32'd0;
    endcase
  endfunction

  function automatic logic ref_cmp(branch_funct3_e op, rv32i_word a, rv32i_word b);
    case (op)
      beq:     return a == b;
      bne:     return a != b;
      blt:     return $signed(a) < $signed(b);
      bge:     return $signed(a) >= $signed(b);
      bltu:    return a < b;
      bgeu:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // EX/MEM wins over MEM/WB and x0 is never forwarded
  function automatic rv32i_word fwd_val(logic en, logic [4:0] idx, rv32i_word base, row_t r);
    logic exm_wr;
    exm_wr = sh_opcode inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg};
    if (!en)
      return base;
    if (exm_wr && sh_rd != 5'd0 && sh_rd == idx)
      return sh_alu;
    if (r.wb_we && r.wb_rd != 5'd0 && r.wb_rd == idx)
      return r.wb_data;
    return base;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: test %0d row %0d %s got %h expected %h",
               $time, cur_tid, cur_row, what, got, exp);
      n_fail++;
      test_err[cur_tid]++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_regs();
    check("ex_opcode", ex_opcode, sh_opcode);
    check("ex_rd", ex_rd, sh_rd);
    check("ex_pc", ex_pc, sh_pc);
    check("ex_alu", ex_alu, sh_alu);
    check("ex_store", ex_store, sh_store);
    check("ex_br_en", ex_br_en, sh_br_en);
    check("ex_be", ex_be, sh_be);
    check("ex_off", ex_off, sh_off);
  endtask

  task automatic drive(input row_t r);
    pc          = r.pc;
    instr       = r.instr;
    opcode      = r.opc;
    aluop       = r.aluop;
    cmpop       = r.cmpop;
    op_a        = r.op_a;
    op_b        = r.op_b;
    rs1_data    = r.rs1d;
    rs2_data    = r.rs2d;
    cmp_b       = r.cmpb;
    mem_wb_we   = r.wb_we;
    mem_wb_rd   = r.wb_rd;
    mem_wb_data = r.wb_data;
    pred        = r.pred;
    ma_stall    = r.stall;
  endtask

  // Expected outputs of row i followed by the shadow register update
  task automatic model_row(input int i);
    row_t r;
    logic [4:0] rs1;
    logic [4:0] rs2;
    rv32i_word a, b, ca, cb, st, res, pc4;
    logic br_en;
    logic [3:0] mask;
    r = rows[i];
    rs1 = r.instr[19:15];
    rs2 = r.instr[24:20];
    a = fwd_val(r.opc inside {op_reg, op_imm, op_load, op_store, op_jalr}, rs1, r.op_a, r);
    b = fwd_val(r.opc == op_reg, rs2, r.op_b, r);
    ca = fwd_val(r.opc inside {op_br, op_reg, op_imm}, rs1, r.rs1d, r);
    cb = fwd_val(r.opc == op_br, rs2, r.cmpb, r);
    st = fwd_val(1'b1, rs2, r.rs2d, r);
    res = ref_alu(r.aluop, a, b);
    br_en = ref_cmp(r.cmpop, ca, cb);
    pc4 = r.pc + 32'd4;
    r.exp_miss = 1'b0;
    r.exp_tgt = pc4;
    if (r.opc == op_jal || r.opc == op_jalr) begin
      r.exp_miss = 1'b1;
      r.exp_tgt = {res[31:1], 1'b0};
    end else if (r.opc == op_br && br_en != r.pred) begin
      r.exp_miss = 1'b1;
      r.exp_tgt = r.pred ? pc4 : res;  // Predicted taken but falls through
    end
    r.exp_upd = (r.opc == op_br);
    r.exp_taken = br_en;
    rows[i] = r;
    case (r.instr[14:12])
      3'b010:         mask = 4'hF;
      3'b001, 3'b101: mask = 4'h3;
      3'b000, 3'b100: mask = 4'h1;
      default:        mask = 4'h0;
    endcase
    if (!r.stall) begin
      sh_opcode = r.opc;
      sh_rd = r.instr[11:7];
      sh_pc = r.pc;
      sh_alu = res;
      sh_store = st;
      sh_br_en = br_en;
      sh_be = (r.opc == op_load || r.opc == op_store) ? 4'(mask << res[1:0]) : 4'h0;
      sh_off = res[1:0];
    end
  endtask

  task automatic build_table();
    row_t r;
    rv32i_word a, b;
    int k;
    alu_op_e ops[10];
    ld_st_funct3_e sizes[3];
    branch_funct3_e cops[6];
    ops = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
            alu_or, alu_and};
    sizes = '{lw, lh, lb};
    cops = '{beq, bne, blt, bge, bltu, bgeu};
    for (k = 0; k < 10; k++) begin
      a = $random(seed);
      b = $random(seed);
      rows.push_back(new_row(1, op_reg, ops[k], enc(op_reg, 5, 0, 6, 7), a, b));
    end
    for (k = 0; k < 12; k++)  // Sizes lw, lh, lb at offsets 0 to 3
      rows.push_back(new_row(1, op_load, alu_add, enc(op_load, 8, sizes[k / 4], 9, 0),
                             32'h2000, 32'(k % 4)));
    rows.push_back(new_row(2, op_imm, alu_add, enc(op_imm, 3, 0, 0, 0), 0, 100));
    rows.push_back(new_row(2, op_reg, alu_add, enc(op_reg, 4, 0, 3, 3), 1, 2));
    r = new_row(2, op_reg, alu_sub, enc(op_reg, 14, 0, 12, 13), 11, 1);
    r.wb_we = 1'b1;
    r.wb_rd = 5'd12;
    r.wb_data = 32'd55;
    rows.push_back(r);
    r = new_row(2, op_reg, alu_or, enc(op_reg, 20, 0, 14, 0), 3, 0);
    r.wb_we = 1'b1;
    r.wb_rd = 5'd14;  // Same rd as EX/MEM
    r.wb_data = 32'd999;
    rows.push_back(r);
    rows.push_back(new_row(2, op_reg, alu_add, enc(op_reg, 0, 0, 1, 2), 7, 8));
    r = new_row(2, op_reg, alu_xor, enc(op_reg, 21, 0, 0, 0), 0, 0);
    r.wb_we = 1'b1;
    r.wb_data = 32'hdead;
    rows.push_back(r);
    rows.push_back(new_row(2, op_imm, alu_add, enc(op_imm, 22, 0, 0, 21), 0, 5));
    rows.push_back(new_row(2, op_lui, alu_add, enc(op_lui, 23, 0, 22, 0), 0, 32'h12345000));
    r = new_row(2, op_store, alu_add, enc(op_store, 0, lw, 0, 23), 32'h3000, 8);
    r.rs2d = 32'h0bad;
    rows.push_back(r);
    for (k = 0; k < 4; k++) begin
      r = new_row(3, op_br, alu_add, enc(op_br, 0, beq, 25, 26), 0, 32'h20);
      r.op_a = r.pc;
      r.rs1d = 32'h40;
      r.cmpb = (k >= 2) ? 32'h40 : 32'h41;
      r.pred = k[0];
      rows.push_back(r);
    end
    for (k = 0; k < 6; k++) begin
      r = new_row(3, op_br, alu_add, enc(op_br, 0, cops[k], 25, 26), 0, 32'hff0);
      r.op_a = r.pc;
      r.cmpop = cops[k];
      r.rs1d = $random(seed);
      r.cmpb = (k < 2) ? r.rs1d : $random(seed);
      a = $random(seed);
      r.pred = a[0];
      rows.push_back(r);
    end
    rows.push_back(new_row(3, op_imm, alu_add, enc(op_imm, 26, 0, 0, 0), 0, 32'h40));
    r = new_row(3, op_br, alu_add, enc(op_br, 0, beq, 25, 26), 0, 32'h40);
    r.op_a = r.pc;
    r.rs1d = 32'h40;
    r.cmpb = 32'h7;
    rows.push_back(r);
    r = new_row(4, op_jal, alu_add, enc(op_jal, 1, 0, 0, 0), 0, 32'h80);
    r.op_a = r.pc;
    rows.push_back(r);
    rows.push_back(new_row(4, op_jalr, alu_add, enc(op_jalr, 1, 0, 10, 0), 32'h1001, 4));
    rows.push_back(new_row(5, op_imm, alu_add, enc(op_imm, 5, 0, 0, 0), 0, 32'h77));
    for (k = 0; k < 4; k++) begin
      r = new_row(5, op_reg, alu_add, enc(op_reg, 6, 0, 5, 0), 1, 32'h10);
      r.pc = 32'h400;
      r.stall = (k < 3);  // Held three cycles then released
      rows.push_back(r);
    end
    rows.push_back(new_row(5, op_reg, alu_sub, enc(op_reg, 7, 0, 6, 0), 2, 3));
  endtask

  task automatic report_test(input int tid);
    $display("Test %0d (%s): %s with %0d errors", tid, test_names[tid],
             (test_err[tid] == 0) ? "done" : "FAILED", test_err[tid]);
  endtask

  initial begin
    int i;
    int n;
    seed = 32'hbe3b;
    n_pass = 0;
    n_fail = 0;
    cur_tid = 5;
    cur_row = -1;
    for (i = 1; i <= 5; i++)
      test_err[i] = 0;
    pc = '0;
    instr = '0;
    opcode = op_imm;
    aluop = alu_add;
    cmpop = beq;
    op_a = '0;
    op_b = '0;
    rs1_data = '0;
    rs2_data = '0;
    cmp_b = '0;
    mem_wb_we = 1'b0;
    mem_wb_rd = '0;
    mem_wb_data = '0;
    pred = 1'b0;
    ma_stall = 1'b1;  // Memory busy until the first row
    sh_opcode = rv32i_opcode_e'(7'd0);
    sh_rd = '0;
    sh_pc = '0;
    sh_alu = '0;
    sh_store = '0;
    sh_br_en = 1'b0;
    sh_be = '0;
    sh_off = '0;
    build_table();
    n = 0;
    while (rst !== 1'b0 && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("Reset was still asserted after %0d cycles", TIMEOUT_CYC);
      n_fail++;
    end else begin
      check_regs();  // Cleared by reset
      for (i = 0; i < rows.size(); i++) begin
        if (i > 0 && rows[i].tid != rows[i - 1].tid)
          report_test(rows[i - 1].tid);
        cur_tid = rows[i].tid;
        cur_row = i;
        @(posedge clk);
        #5;
        drive(rows[i]);
        #40;
        check_regs();
        model_row(i);
        check("pcmux_sel", pcmux_sel, rows[i].exp_miss ? pc_target : pc_plus4);
        check("target", target, rows[i].exp_tgt);
        check("br_miss", br_miss, rows[i].exp_miss);
        check("pred_update", pred_update, rows[i].exp_upd);
        if (rows[i].opc == op_br)
          check("pred_taken", pred_taken, rows[i].exp_taken);
      end
      @(posedge clk);
      #45;
      cur_row = rows.size();
      check_regs();
      report_test(cur_tid);
    end
    if (u_dut.u_assert.fail_count != 0) begin
      $display("Bound assertions failed %0d times", u_dut.u_assert.fail_count);
      n_fail += u_dut.u_assert.fail_count;
    end
    $display("Checks passed: %0d, checks failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/rv32i_types_pkg.sv
hdl/ex_ctrl_pkg.sv
hdl/ex_forward.sv
hdl/ex_alu.sv
hdl/ex_cmp.sv
hdl/ex_resolve.sv
hdl/ex_stage.sv
sim/ex_stage_assert.sv
sim/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv32i_types_pkg.sv
      - hdl/ex_ctrl_pkg.sv
      - hdl/ex_forward.sv
      - hdl/ex_alu.sv
      - hdl/ex_cmp.sv
      - hdl/ex_resolve.sv
      - hdl/ex_stage.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/ex_stage_assert.sv
      - sim/tb_ex_stage.sv
